/* build.f */
rtl/irq_pkg.sv
rtl/intr_capturer.sv
rtl/intr_pending_ctrl.sv
rtl/csr_arbiter.sv
rtl/host_port.sv
rtl/irq_subsystem_top.sv
verification/irq_subsystem_tb.sv

/* rtl/csr_arbiter.sv */
`timescale 1ns/1ps

module csr_arbiter (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [1:0]          q_valid,
  input  irq_pkg::host_req_t  q_req [2],
  input  irq_pkg::csr_data_t  cap_rdata,
  input  irq_pkg::csr_data_t  pend_rdata,
  output logic [1:0]          grant,
  output irq_pkg::csr_req_t   cap_bus,
  output irq_pkg::csr_req_t   pend_bus,
  output logic [1:0]          resp_valid,
  output irq_pkg::csr_data_t  resp_data
);

  import irq_pkg::*;

  // port that won the previous arbitration
  logic last;

  // port chosen in this cycle, meaningful only when some port is valid
  logic pick;
  logic any_req;

  host_req_t win_req;
  logic      sel_cap;
  logic      sel_pend;

  // one cycle record of the grant, used to steer the response
  logic rsp_pend;
  logic rsp_port;

  // with both ports waiting the loser of the last round goes first
  always_comb begin
    if (q_valid == 2'b11) begin
      pick = ~last;
    end else begin
      pick = q_valid[1];
    end
  end

  assign any_req = |q_valid;
  assign grant   = any_req ? (pick ? 2'b10 : 2'b01) : 2'b00;
  assign win_req = q_req[pick];

  // words 0 and 1 belong to the capturer, 2 to 5 to the pending block,
  // and words 6 and 7 select neither so they read as zero
  assign sel_cap  = (win_req.addr == ADDR_LEVEL_LO) || (win_req.addr == ADDR_LEVEL_HI);
  assign sel_pend = win_req.addr inside {ADDR_PEND_LO, ADDR_PEND_HI,
                                         ADDR_MASK_LO, ADDR_MASK_HI};

  always_comb begin
    cap_bus.read   = any_req && !win_req.write && sel_cap;
    cap_bus.write  = any_req && win_req.write && sel_cap;
    cap_bus.addr   = win_req.addr;
    cap_bus.wdata  = win_req.wdata;
    pend_bus.read  = any_req && !win_req.write && sel_pend;
    pend_bus.write = any_req && win_req.write && sel_pend;
    pend_bus.addr  = win_req.addr;
    pend_bus.wdata = win_req.wdata;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last     <= 1'b1;
      rsp_pend <= 1'b0;
      rsp_port <= 1'b0;
    end else begin
      rsp_pend <= any_req;
      if (any_req) begin
        last     <= pick;
        rsp_port <= pick;
      end
    end
  end

  // unselected targets drive zero, so an OR is the whole read mux
  assign resp_data  = cap_rdata | pend_rdata;
  assign resp_valid = {rsp_pend && rsp_port, rsp_pend && !rsp_port};

  // grant at most one port and only one that shows a request
  a_grant_onehot : assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(grant) && ((grant & ~q_valid) == 2'b00))
    else $error("csr_arbiter: bad grant %b with q_valid %b", grant, q_valid);

endmodule

/* rtl/host_port.sv */
`timescale 1ns/1ps

module host_port #(
  parameter int REQ_DEPTH = 2
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_valid,
  input  irq_pkg::host_req_t  req,
  input  logic                grant,
  input  logic                resp_valid,
  input  irq_pkg::csr_data_t  resp_data,
  output logic                credit,
  output logic                rsp_valid,
  output irq_pkg::host_rsp_t  rsp,
  output logic                q_valid,
  output irq_pkg::host_req_t  q_req
);

  import irq_pkg::*;

  localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
  localparam int CNT_W = $clog2(REQ_DEPTH + 1);

  // request storage, one entry per credit
  host_req_t mem [REQ_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;
  logic             full;

  // pointers wrap at REQ_DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(REQ_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // the host only sends while it holds a credit, so a push never meets a full queue
  assign push = req_valid;
  assign pop  = grant && q_valid;
  assign full = (count == CNT_W'(REQ_DEPTH));

  assign q_valid = (count != '0);
  assign q_req   = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= req;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // each entry that leaves for the bus hands one credit back
      credit <= pop;
    end
  end

  // responses arrive in grant order, which is request order for this port
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= resp_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (resp_valid) begin
      rsp.rdata <= resp_data;
    end
  end

  // a request into a full queue means the host spent a credit it did not have
  a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n) req_valid |-> !full)
    else $error("host_port: req_valid with full queue, count %0d", count);

endmodule

/* rtl/intr_capturer.sv */
`timescale 1ns/1ps

module intr_capturer #(
  parameter int NUM_INTR = 48
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [NUM_INTR-1:0]  interrupt_in,
  input  irq_pkg::csr_req_t    bus,
  output irq_pkg::csr_data_t   rdata,
  output logic [NUM_INTR-1:0]  intr_level
);

  import irq_pkg::*;

  // interrupt lines after one register stage
  logic [NUM_INTR-1:0] intr_reg;

  // the level vector widened to two full words, upper bits read as zero
  logic [63:0] level_ext;

  // read data before the wait-state register
  csr_data_t rdata_next;

  // the interrupt lines are active-high levels and are sampled every cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      intr_reg <= '0;
    end else begin
      intr_reg <= interrupt_in;
    end
  end

  assign level_ext  = 64'(intr_reg);
  assign intr_level = intr_reg;

  // only a read strobe with one of the two level addresses selects a word,
  // anything else gives zero so the arbiter can OR the targets together
  always_comb begin
    rdata_next = '0;
    if (bus.read) begin
      if (bus.addr == ADDR_LEVEL_LO) begin
        rdata_next = level_ext[31:0];
      end else if (bus.addr == ADDR_LEVEL_HI) begin
        rdata_next = level_ext[63:32];
      end
    end
  end

  // the read data register is the single wait state of this target
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata <= '0;
    end else begin
      rdata <= rdata_next;
    end
  end

  // the arbiter never routes a write here since the level words are read-only
  a_no_write : assert property (@(posedge clk) disable iff (!rst_n) !bus.write)
    else $error("intr_capturer: write presented to read-only level words");

endmodule

/* rtl/intr_pending_ctrl.sv */
`timescale 1ns/1ps

module intr_pending_ctrl #(
  parameter int NUM_INTR = 48
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [NUM_INTR-1:0]  intr_level,
  input  irq_pkg::csr_req_t    bus,
  output irq_pkg::csr_data_t   rdata,
  output logic                 irq
);

  import irq_pkg::*;

  // level_d holds the previous level so that 0 to 1 transitions can be found
  logic [NUM_INTR-1:0] level_d;
  logic [NUM_INTR-1:0] rise;

  // sticky pending bits and the enable mask
  logic [NUM_INTR-1:0] pending;
  logic [NUM_INTR-1:0] mask;

  // both registers widened to two words for the CSR side
  logic [63:0] pend_ext;
  logic [63:0] mask_ext;

  // write data moved into the half that the address picks and a select of that half
  logic [63:0] wr_pos;
  logic [63:0] wr_sel;
  logic [63:0] pend_clr;
  logic [63:0] mask_next;

  logic      pend_wr;
  logic      mask_wr;
  csr_data_t rdata_next;

  assign rise     = intr_level & ~level_d;
  assign pend_ext = 64'(pending);
  assign mask_ext = 64'(mask);

  // odd word addresses are the upper half in both register pairs
  assign wr_pos = bus.addr[0] ? {bus.wdata, 32'h0} : {32'h0, bus.wdata};
  assign wr_sel = bus.addr[0] ? {32'hffff_ffff, 32'h0} : {32'h0, 32'hffff_ffff};

  assign pend_wr = bus.write && (bus.addr == ADDR_PEND_LO || bus.addr == ADDR_PEND_HI);
  assign mask_wr = bus.write && (bus.addr == ADDR_MASK_LO || bus.addr == ADDR_MASK_HI);

  assign pend_clr  = pend_wr ? wr_pos : 64'h0;
  assign mask_next = mask_wr ? ((mask_ext & ~wr_sel) | wr_pos) : mask_ext;

  // a new edge sets its bit even when the same bit is cleared in this cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      level_d <= '0;
      pending <= '0;
      mask    <= '0;
    end else begin
      level_d <= intr_level;
      pending <= (pending & ~pend_clr[NUM_INTR-1:0]) | rise;
      mask    <= mask_next[NUM_INTR-1:0];
    end
  end

  // reads follow the capturer and give zero unless one of our words is read
  always_comb begin
    rdata_next = '0;
    if (bus.read) begin
      case (bus.addr)
        ADDR_PEND_LO: rdata_next = pend_ext[31:0];
        ADDR_PEND_HI: rdata_next = pend_ext[63:32];
        ADDR_MASK_LO: rdata_next = mask_ext[31:0];
        ADDR_MASK_HI: rdata_next = mask_ext[63:32];
        default:      rdata_next = '0;
      endcase
    end
  end

  // irq lags the pending and mask registers by one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata <= '0;
      irq   <= 1'b0;
    end else begin
      rdata <= rdata_next;
      irq   <= |(pending & mask);
    end
  end

endmodule

/* rtl/irq_pkg.sv */
package irq_pkg;

  // one word on the CSR bus
  typedef logic [31:0] csr_data_t;

  // word address, eight words in the whole map
  typedef logic [2:0] csr_addr_t;

  // captured interrupt levels, read-only
  localparam csr_addr_t ADDR_LEVEL_LO = 3'd0;
  localparam csr_addr_t ADDR_LEVEL_HI = 3'd1;

  // sticky pending bits, a written 1 clears the bit
  localparam csr_addr_t ADDR_PEND_LO = 3'd2;
  localparam csr_addr_t ADDR_PEND_HI = 3'd3;

  // enable mask, a 1 lets the pending bit reach irq
  localparam csr_addr_t ADDR_MASK_LO = 3'd4;
  localparam csr_addr_t ADDR_MASK_HI = 3'd5;

  // request as it leaves a host, a read when write is low
  typedef struct packed {
    logic      write;
    csr_addr_t addr;
    csr_data_t wdata;
  } host_req_t;

  // response to a host, zero for writes
  typedef struct packed {
    csr_data_t rdata;
  } host_rsp_t;

  // request on the shared CSR bus, at most one strobe is set
  typedef struct packed {
    logic      read;
    logic      write;
    csr_addr_t addr;
    csr_data_t wdata;
  } csr_req_t;

endpackage

/* rtl/irq_subsystem_top.sv */
`timescale 1ns/1ps

module irq_subsystem_top #(
  parameter int NUM_INTR  = 48,
  parameter int REQ_DEPTH = 2
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [NUM_INTR-1:0]  interrupt_in,
  input  logic                 host0_req_valid,
  input  irq_pkg::host_req_t   host0_req,
  input  logic                 host1_req_valid,
  input  irq_pkg::host_req_t   host1_req,
  output logic                 host0_credit,
  output logic                 host0_rsp_valid,
  output irq_pkg::host_rsp_t   host0_rsp,
  output logic                 host1_credit,
  output logic                 host1_rsp_valid,
  output irq_pkg::host_rsp_t   host1_rsp,
  output logic                 irq
);

  import irq_pkg::*;

  // queue heads towards the arbiter and the grant and response back
  logic [1:0] q_valid;
  host_req_t  q_req [2];
  logic [1:0] grant;
  logic [1:0] resp_valid;
  csr_data_t  resp_data;

  // one request bus and one read data word per target
  csr_req_t  cap_bus;
  csr_req_t  pend_bus;
  csr_data_t cap_rdata;
  csr_data_t pend_rdata;

  // registered levels shared by both targets
  logic [NUM_INTR-1:0] intr_level;

  host_port #(.REQ_DEPTH(REQ_DEPTH)) u_host0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (host0_req_valid),
    .req        (host0_req),
    .grant      (grant[0]),
    .resp_valid (resp_valid[0]),
    .resp_data  (resp_data),
    .credit     (host0_credit),
    .rsp_valid  (host0_rsp_valid),
    .rsp        (host0_rsp),
    .q_valid    (q_valid[0]),
    .q_req      (q_req[0])
  );

  host_port #(.REQ_DEPTH(REQ_DEPTH)) u_host1 (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (host1_req_valid),
    .req        (host1_req),
    .grant      (grant[1]),
    .resp_valid (resp_valid[1]),
    .resp_data  (resp_data),
    .credit     (host1_credit),
    .rsp_valid  (host1_rsp_valid),
    .rsp        (host1_rsp),
    .q_valid    (q_valid[1]),
    .q_req      (q_req[1])
  );

  csr_arbiter u_arbiter (
    .clk        (clk),
    .rst_n      (rst_n),
    .q_valid    (q_valid),
    .q_req      (q_req),
    .cap_rdata  (cap_rdata),
    .pend_rdata (pend_rdata),
    .grant      (grant),
    .cap_bus    (cap_bus),
    .pend_bus   (pend_bus),
    .resp_valid (resp_valid),
    .resp_data  (resp_data)
  );

  intr_capturer #(.NUM_INTR(NUM_INTR)) u_capturer (
    .clk          (clk),
    .rst_n        (rst_n),
    .interrupt_in (interrupt_in),
    .bus          (cap_bus),
    .rdata        (cap_rdata),
    .intr_level   (intr_level)
  );

  intr_pending_ctrl #(.NUM_INTR(NUM_INTR)) u_pending (
    .clk        (clk),
    .rst_n      (rst_n),
    .intr_level (intr_level),
    .bus        (pend_bus),
    .rdata      (pend_rdata),
    .irq        (irq)
  );

endmodule

/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module irq_subsystem_tb -f build.f -o irq_sim \
  || { echo "verilator build failed"; exit 1; }

out="$(./obj_dir/irq_sim)"
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx "TEST RESULT: PASS" \
  && exit 0 \
  || { echo "simulation did not report a pass"; exit 1; }

/* verification/irq_subsystem_tb.sv */
`timescale 1ns/1ps

module irq_subsystem_tb;

  import irq_pkg::*;

  localparam int NUM_INTR  = 48;
  localparam int REQ_DEPTH = 2;
  localparam int LOAD_REQS = 500;
  // directed phases stay under 1000 cycles and the load phase runs near one grant per cycle
  localparam int MAX_CYCLES = 2 * (1000 + 2 * LOAD_REQS);
  localparam logic [63:0] VALID_BITS = {64{1'b1}} >> (64 - NUM_INTR);

  logic                clk = 1'b0;
  logic                rst_n;
  logic [NUM_INTR-1:0] interrupt_in;
  logic [1:0]          req_valid;
  host_req_t           req [2];
  logic [1:0]          credit;
  logic [1:0]          rsp_valid;
  host_rsp_t           rsp [2];
  logic                irq;

  // register map model that is updated when a request is issued
  logic [63:0] model_level;
  logic [63:0] model_pend;
  logic [63:0] model_mask;
  csr_data_t   exp_q0 [$];
  csr_data_t   exp_q1 [$];

  // host side bookkeeping is written at the falling edge or just after the rising edge
  int issued [2];
  int credits_seen [2];
  int held [2];
  int run [2];
  int rsp_seen [2];
  int intr_quiet;
  int errors;
  int cycles;
  logic started;

  // values captured at the falling edge for the checks at the next rising edge
  logic [1:0] chk_valid;
  logic [1:0] chk_empty;
  csr_data_t  chk_got [2];
  csr_data_t  chk_exp [2];
  logic       irq_chk;
  logic       irq_seen;
  logic       irq_exp;
  logic       idle_seen;

  logic [31:0] lfsr_state = 32'h039a43a0;

  irq_subsystem_top #(.NUM_INTR(NUM_INTR), .REQ_DEPTH(REQ_DEPTH)) u_dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .interrupt_in    (interrupt_in),
    .host0_req_valid (req_valid[0]),
    .host0_req       (req[0]),
    .host1_req_valid (req_valid[1]),
    .host1_req       (req[1]),
    .host0_credit    (credit[0]),
    .host0_rsp_valid (rsp_valid[0]),
    .host0_rsp       (rsp[0]),
    .host1_credit    (credit[1]),
    .host1_rsp_valid (rsp_valid[1]),
    .host1_rsp       (rsp[1]),
    .irq             (irq)
  );

  always #20 clk = ~clk;

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one LFSR step per bit handed out
  function automatic logic [63:0] rand_bits(int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  function automatic void push_exp(int p, csr_data_t v);
    if (p == 0) begin
      exp_q0.push_back(v);
    end else begin
      exp_q1.push_back(v);
    end
  endfunction

  function automatic int exp_count(int p);
    return (p == 0) ? exp_q0.size() : exp_q1.size();
  endfunction

  function automatic csr_data_t pop_exp(int p);
    if (p == 0 && exp_q0.size() != 0) begin
      return exp_q0.pop_front();
    end
    if (p == 1 && exp_q1.size() != 0) begin
      return exp_q1.pop_front();
    end
    return '0;
  endfunction

  // odd addresses are the upper word of a pair and a read of 6 or 7 gives zero
  function automatic csr_data_t model_access(logic wr, csr_addr_t addr, csr_data_t wdata);
    logic [63:0] word_sel;
    logic [63:0] wpos;
    csr_data_t   rd;
    word_sel = addr[0] ? {32'hffff_ffff, 32'h0} : {32'h0, 32'hffff_ffff};
    wpos     = addr[0] ? {wdata, 32'h0} : {32'h0, wdata};
    rd       = '0;
    if (wr) begin
      if (addr == ADDR_PEND_LO || addr == ADDR_PEND_HI) begin
        model_pend = model_pend & ~wpos;
      end else if (addr == ADDR_MASK_LO || addr == ADDR_MASK_HI) begin
        model_mask = ((model_mask & ~word_sel) | wpos) & VALID_BITS;
      end
    end else if (addr == ADDR_LEVEL_LO || addr == ADDR_LEVEL_HI) begin
      rd = addr[0] ? model_level[63:32] : model_level[31:0];
    end else if (addr == ADDR_PEND_LO || addr == ADDR_PEND_HI) begin
      rd = addr[0] ? model_pend[63:32] : model_pend[31:0];
    end else if (addr == ADDR_MASK_LO || addr == ADDR_MASK_HI) begin
      rd = addr[0] ? model_mask[63:32] : model_mask[31:0];
    end
    return rd;
  endfunction

  // host 0 owns the low mask word, host 1 the pending words and the high mask word,
  // so the model result does not depend on how the two ports interleave
  function automatic csr_addr_t load_addr(int p, logic [2:0] pick);
    csr_addr_t a;
    if (p == 0) begin
      case (pick[1:0])
        2'd0:    a = ADDR_LEVEL_LO;
        2'd2:    a = 3'd6;
        default: a = ADDR_MASK_LO;
      endcase
    end else begin
      case (pick)
        3'd0:       a = ADDR_LEVEL_HI;
        3'd1, 3'd5: a = ADDR_PEND_LO;
        3'd2, 3'd6: a = ADDR_PEND_HI;
        3'd3:       a = ADDR_MASK_HI;
        default:    a = 3'd7;
      endcase
    end
    return a;
  endfunction

  // spends one credit and waits for one to come back when none is held
  task automatic issue(input int p, input logic wr, input csr_addr_t addr,
                       input csr_data_t wdata);
    host_req_t r;
    while (held[p] == 0) begin
      @(posedge clk);
      #1;
    end
    push_exp(p, model_access(wr, addr, wdata));
    r.write      = wr;
    r.addr       = addr;
    r.wdata      = wdata;
    req[p]       = r;
    req_valid[p] = 1'b1;
    held[p]--;
    issued[p]++;
    started      = 1'b1;
    @(posedge clk);
    #1;
    req_valid[p] = 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_count(0) != 0 || exp_count(1) != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic xfer(input int p, input logic wr, input csr_addr_t addr, input csr_data_t wdata);
    issue(p, wr, addr, wdata);
    wait_idle();
  endtask

  // gives the irq check a few quiet cycles
  task automatic settle();
    wait_idle();
    repeat (3) @(posedge clk);
    #1;
  endtask

  // a rising input bit becomes pending once it has passed both register stages
  task automatic set_intr(input logic [NUM_INTR-1:0] v);
    model_pend   = model_pend | 64'(v & ~interrupt_in);
    interrupt_in = v;
    model_level  = 64'(v);
    intr_quiet   = 0;
    repeat (4) @(posedge clk);
    #1;
  endtask

  task automatic load_host(input int p);
    csr_addr_t addr;
    logic      wr;
    csr_data_t wdata;
    for (int i = 0; i < LOAD_REQS; i++) begin
      addr  = load_addr(p, 3'(rand_bits(3)));
      wr    = rand_bits(1) != 0;
      wdata = 32'(rand_bits(32));
      // level words are read-only
      if (addr == ADDR_LEVEL_LO || addr == ADDR_LEVEL_HI) begin
        wr = 1'b0;
      end
      issue(p, wr, addr, wdata);
    end
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      for (int p = 0; p < 2; p++) begin
        chk_valid[p] <= rsp_valid[p];
        chk_got[p]   <= rsp[p].rdata;
        if (rsp_valid[p]) begin
          chk_empty[p] <= (exp_count(p) == 0);
          chk_exp[p]   <= pop_exp(p);
          rsp_seen[p]++;
        end
        // a run only grows while the other port has a request waiting
        if (credit[p]) begin
          if (issued[1-p] - credits_seen[1-p] > 0) begin
            run[p]++;
          end else begin
            run[p] = 0;
          end
          run[1-p] = 0;
          credits_seen[p]++;
          held[p]++;
        end
      end
      if (intr_quiet < 100) begin
        intr_quiet++;
      end
      irq_chk   <= (exp_count(0) == 0) && (exp_count(1) == 0) && (intr_quiet >= 4);
      irq_seen  <= irq;
      irq_exp   <= |(model_pend & model_mask);
      idle_seen <= !irq && (credit == 2'b00) && (rsp_valid == 2'b00);
    end
  end

  for (genvar p = 0; p < 2; p++) begin : g_port
    a_rsp_expected : assert property (@(posedge clk) disable iff (!rst_n)
      chk_valid[p] |-> !chk_empty[p])
      else begin
        errors++;
        $display("host%0d returned a response with no request outstanding", p);
      end
    a_rsp_data : assert property (@(posedge clk) disable iff (!rst_n)
      (chk_valid[p] && !chk_empty[p]) |-> (chk_got[p] == chk_exp[p]))
      else begin
        errors++;
        $display("error: host%0d_rsp.rdata got %h expected %h", p, chk_got[p], chk_exp[p]);
      end
    a_credit_bound : assert property (@(posedge clk) disable iff (!rst_n)
      credits_seen[p] <= issued[p])
      else begin
        errors++;
        $display("host%0d pulsed credit with no request outstanding", p);
      end
    // a request counts as outstanding until its response has come back
    a_outstanding : assert property (@(posedge clk) disable iff (!rst_n)
      (issued[p] - rsp_seen[p]) <= REQ_DEPTH)
      else begin
        errors++;
        $display("host%0d has more requests waiting for a response than it has credits", p);
      end
    a_fair : assert property (@(posedge clk) disable iff (!rst_n) run[p] <= 2)
      else begin
        errors++;
        $display("host%0d won more than two grants in a row while the other port waited", p);
      end
  end

  a_idle : assert property (@(posedge clk) disable iff (!rst_n) !started |-> idle_seen)
    else begin
      errors++;
      $display("irq, credit or rsp_valid went high before any request was issued");
    end

  a_irq : assert property (@(posedge clk) disable iff (!rst_n) irq_chk |-> (irq_seen == irq_exp))
    else begin
      errors++;
      $display("error: irq got %h expected %h", irq_seen, irq_exp);
    end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles before all responses came back", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    int          k;
    csr_addr_t   pw;
    csr_addr_t   mw;
    csr_data_t   bitw;
    logic [NUM_INTR-1:0] bitv;
    rst_n        = 1'b0;
    interrupt_in = '0;
    req_valid    = 2'b00;
    req[0]       = '0;
    req[1]       = '0;
    model_level  = '0;
    model_pend   = '0;
    model_mask   = '0;
    started      = 1'b0;
    chk_valid    = 2'b00;
    chk_empty    = 2'b00;
    irq_chk      = 1'b0;
    idle_seen    = 1'b1;
    intr_quiet   = 0;
    errors       = 0;
    cycles       = 0;
    for (int p = 0; p < 2; p++) begin
      issued[p]       = 0;
      credits_seen[p] = 0;
      held[p]         = REQ_DEPTH;
      run[p]          = 0;
      rsp_seen[p]     = 0;
    end
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (4) @(posedge clk);
    #1;

    // pending and mask words start out clear
    for (int a = 2; a < 6; a++) begin
      xfer(0, 1'b0, csr_addr_t'(a), '0);
    end

    // level readback including the unused upper bits and words 6 and 7
    repeat (6) begin
      set_intr(NUM_INTR'(rand_bits(NUM_INTR)));
      xfer(0, 1'b0, ADDR_LEVEL_LO, '0);
      xfer(1, 1'b0, ADDR_LEVEL_HI, '0);
      xfer(0, 1'b0, 3'd6, '0);
      xfer(1, 1'b0, 3'd7, '0);
    end

    // one input bit at a time is set on the edge, cleared by W1C and set again on a new edge
    for (int n = 0; n < 4; n++) begin
      k       = int'(rand_bits(6)) % NUM_INTR;
      bitv    = '0;
      bitv[k] = 1'b1;
      pw      = (k >= 32) ? ADDR_PEND_HI : ADDR_PEND_LO;
      bitw    = 32'h1 << (k % 32);
      set_intr('0);
      xfer(1, 1'b1, ADDR_PEND_LO, 32'hffff_ffff);
      xfer(1, 1'b1, ADDR_PEND_HI, 32'hffff_ffff);
      set_intr(bitv);
      xfer(0, 1'b0, pw, '0);
      xfer(1, 1'b1, pw, bitw);
      xfer(0, 1'b0, pw, '0);
      set_intr('0);
      set_intr(bitv);
      xfer(1, 1'b0, pw, '0);
    end

    // bit k is still pending here, so the mask alone decides irq
    mw = (k >= 32) ? ADDR_MASK_HI : ADDR_MASK_LO;
    settle();
    xfer(0, 1'b1, mw, bitw);
    settle();
    xfer(1, 1'b1, mw, '0);
    settle();
    xfer(0, 1'b1, mw, bitw);
    settle();
    xfer(1, 1'b1, pw, bitw);
    settle();
    xfer(0, 1'b0, mw, '0);

    // both hosts flat out on the shared bus
    set_intr(NUM_INTR'(rand_bits(NUM_INTR)));
    fork
      load_host(0);
      load_host(1);
    join
    settle();

    for (int p = 0; p < 2; p++) begin
      assert (credits_seen[p] == issued[p])
        else begin
          errors++;
          $display("error: host%0d credit count got %h expected %h", p, credits_seen[p],
                   issued[p]);
        end
    end
    $display("errors %0d, responses host0 %0d host1 %0d, requests host0 %0d host1 %0d",
             errors, rsp_seen[0], rsp_seen[1], issued[0], issued[1]);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
